/* logic/axil_xbar_pkg.sv */
package axil_xbar_pkg;

    // Port counts
    localparam int NM = 2;
    localparam int NS = 3;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Address map, one 4 KiB window per register bank
    localparam logic [NS-1:0][ADDR_W-1:0] SLAVE_BASE = {
        32'h0000_3000,
        32'h0000_2000,
        32'h0000_1000
    };
    localparam logic [ADDR_W-1:0] SLAVE_MASK = 32'hFFFF_F000;

    // Target index, value NS selects the decode-error responder
    localparam int TGT_W = 2;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
    } axil_r_t;

endpackage

/* logic/axil_addr_decode.sv */
module axil_addr_decode (
    input  logic [axil_xbar_pkg::ADDR_W-1:0] addr,
    output logic [axil_xbar_pkg::TGT_W-1:0]  tgt
);

    // Miss falls through to the decode-error target
    always_comb begin
        tgt = axil_xbar_pkg::TGT_W'(axil_xbar_pkg::NS);
        for (int i = axil_xbar_pkg::NS - 1; i >= 0; i--) begin
            if ((addr & axil_xbar_pkg::SLAVE_MASK) == axil_xbar_pkg::SLAVE_BASE[i]) begin
                tgt = axil_xbar_pkg::TGT_W'(i);
            end
        end
    end

endmodule

/* logic/axil_rr_arbiter.sv */
module axil_rr_arbiter (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic [axil_xbar_pkg::NM-1:0] req,
    input  logic                         grant_release,
    output logic [axil_xbar_pkg::NM-1:0] grant,
    output logic                         busy
);

    logic [axil_xbar_pkg::NM-1:0] last;
    logic [axil_xbar_pkg::NM-1:0] pick;

    // Search starts one past the previous winner
    always_comb begin
        int p;
        int c;
        p    = 0;
        pick = '0;
        for (int i = 0; i < axil_xbar_pkg::NM; i++) begin
            if (last[i]) begin
                p = i;
            end
        end
        // Nearest requester wins, so scan from the far end
        for (int k = axil_xbar_pkg::NM; k >= 1; k--) begin
            c = (p + k) % axil_xbar_pkg::NM;
            if (req[c]) begin
                pick    = '0;
                pick[c] = 1'b1;
            end
        end
    end

    assign busy = |grant;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            grant <= '0;
            // Last winner set to the top master so master 0 goes first
            last  <= {1'b1, {(axil_xbar_pkg::NM - 1){1'b0}}};
        end else if (busy) begin
            if (grant_release) begin
                grant <= '0;
            end
        end else if (|req) begin
            grant <= pick;
            last  <= pick;
        end
    end

endmodule

/* logic/axil_xbar_write.sv */
module axil_xbar_write (
    input  logic                              clock,
    input  logic                              arst_n,
    input  axil_xbar_pkg::axil_aw_t           m_aw [axil_xbar_pkg::NM],
    input  logic [axil_xbar_pkg::NM-1:0]      m_aw_valid,
    output logic [axil_xbar_pkg::NM-1:0]      m_aw_ready,
    input  axil_xbar_pkg::axil_w_t            m_w [axil_xbar_pkg::NM],
    input  logic [axil_xbar_pkg::NM-1:0]      m_w_valid,
    output logic [axil_xbar_pkg::NM-1:0]      m_w_ready,
    output axil_xbar_pkg::axil_b_t            m_b [axil_xbar_pkg::NM],
    output logic [axil_xbar_pkg::NM-1:0]      m_b_valid,
    input  logic [axil_xbar_pkg::NM-1:0]      m_b_ready,
    output axil_xbar_pkg::axil_aw_t           s_aw [axil_xbar_pkg::NS],
    output logic [axil_xbar_pkg::NS-1:0]      s_aw_valid,
    input  logic [axil_xbar_pkg::NS-1:0]      s_aw_ready,
    output axil_xbar_pkg::axil_w_t            s_w [axil_xbar_pkg::NS],
    output logic [axil_xbar_pkg::NS-1:0]      s_w_valid,
    input  logic [axil_xbar_pkg::NS-1:0]      s_w_ready,
    input  axil_xbar_pkg::axil_b_t            s_b [axil_xbar_pkg::NS],
    input  logic [axil_xbar_pkg::NS-1:0]      s_b_valid,
    output logic [axil_xbar_pkg::NS-1:0]      s_b_ready
);

    logic [axil_xbar_pkg::TGT_W-1:0] tgt [axil_xbar_pkg::NM];
    logic [axil_xbar_pkg::NM-1:0]    req [axil_xbar_pkg::NS+1];
    logic [axil_xbar_pkg::NM-1:0]    grant [axil_xbar_pkg::NS+1];
    logic [axil_xbar_pkg::NS:0]      busy;
    logic [axil_xbar_pkg::NS:0]      rel;

    // Target side, index NS is the decode-error responder
    axil_xbar_pkg::axil_aw_t    t_aw [axil_xbar_pkg::NS+1];
    axil_xbar_pkg::axil_w_t     t_w [axil_xbar_pkg::NS+1];
    axil_xbar_pkg::axil_b_t     t_b [axil_xbar_pkg::NS+1];
    logic [axil_xbar_pkg::NS:0] t_aw_valid, t_aw_ready;
    logic [axil_xbar_pkg::NS:0] t_w_valid, t_w_ready;
    logic [axil_xbar_pkg::NS:0] t_b_valid, t_b_ready;

    logic de_ready;
    logic de_bvalid;

    for (genvar m = 0; m < axil_xbar_pkg::NM; m++) begin : g_dec
        axil_addr_decode dec (
            .addr(m_aw[m].addr),
            .tgt (tgt[m])
        );
    end

    for (genvar t = 0; t <= axil_xbar_pkg::NS; t++) begin : g_arb
        axil_rr_arbiter arb (
            .clock        (clock),
            .arst_n       (arst_n),
            .req          (req[t]),
            .grant_release(rel[t]),
            .grant        (grant[t]),
            .busy         (busy[t])
        );
        assign rel[t] = t_b_valid[t] && t_b_ready[t];
    end

    // Request only with address and data both present
    always_comb begin
        for (int t = 0; t <= axil_xbar_pkg::NS; t++) begin
            for (int m = 0; m < axil_xbar_pkg::NM; m++) begin
                req[t][m] = m_aw_valid[m] && m_w_valid[m] && !busy[t]
                            && (int'(tgt[m]) == t);
            end
        end
    end

    // Granted master drives each target
    always_comb begin
        for (int t = 0; t <= axil_xbar_pkg::NS; t++) begin
            t_aw[t]       = '0;
            t_w[t]        = '0;
            t_aw_valid[t] = 1'b0;
            t_w_valid[t]  = 1'b0;
            t_b_ready[t]  = 1'b0;
            for (int m = 0; m < axil_xbar_pkg::NM; m++) begin
                if (grant[t][m]) begin
                    t_aw[t]       = m_aw[m];
                    t_w[t]        = m_w[m];
                    t_aw_valid[t] = m_aw_valid[m];
                    t_w_valid[t]  = m_w_valid[m];
                    t_b_ready[t]  = m_b_ready[m];
                end
            end
        end
    end

    // Ready and response come back from whichever target holds the master
    always_comb begin
        for (int m = 0; m < axil_xbar_pkg::NM; m++) begin
            m_aw_ready[m] = 1'b0;
            m_w_ready[m]  = 1'b0;
            m_b[m]        = '0;
            m_b_valid[m]  = 1'b0;
            for (int t = 0; t <= axil_xbar_pkg::NS; t++) begin
                if (grant[t][m]) begin
                    m_aw_ready[m] = t_aw_ready[t];
                    m_w_ready[m]  = t_w_ready[t];
                    m_b[m]        = t_b[t];
                    m_b_valid[m]  = t_b_valid[t];
                end
            end
        end
    end

    for (genvar s = 0; s < axil_xbar_pkg::NS; s++) begin : g_port
        assign s_aw[s]       = t_aw[s];
        assign s_aw_valid[s] = t_aw_valid[s];
        assign s_w[s]        = t_w[s];
        assign s_w_valid[s]  = t_w_valid[s];
        assign s_b_ready[s]  = t_b_ready[s];
        assign t_aw_ready[s] = s_aw_ready[s];
        assign t_w_ready[s]  = s_w_ready[s];
        assign t_b[s]        = s_b[s];
        assign t_b_valid[s]  = s_b_valid[s];
    end

    // Decode-error responder
    assign t_aw_ready[axil_xbar_pkg::NS] = de_ready;
    assign t_w_ready[axil_xbar_pkg::NS]  = de_ready;
    assign t_b[axil_xbar_pkg::NS]        = '{resp: axil_xbar_pkg::RESP_DECERR};
    assign t_b_valid[axil_xbar_pkg::NS]  = de_bvalid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            de_ready  <= 1'b0;
            de_bvalid <= 1'b0;
        end else begin
            // One-cycle accept window the cycle after the grant
            de_ready <= busy[axil_xbar_pkg::NS] && !de_ready && !de_bvalid;
            if (de_ready && t_aw_valid[axil_xbar_pkg::NS] && t_w_valid[axil_xbar_pkg::NS]) begin
                de_bvalid <= 1'b1;
            end else if (de_bvalid && t_b_ready[axil_xbar_pkg::NS]) begin
                de_bvalid <= 1'b0;
            end
        end
    end

endmodule

/* logic/axil_xbar_read.sv */
module axil_xbar_read (
    input  logic                              clock,
    input  logic                              arst_n,
    input  axil_xbar_pkg::axil_ar_t           m_ar [axil_xbar_pkg::NM],
    input  logic [axil_xbar_pkg::NM-1:0]      m_ar_valid,
    output logic [axil_xbar_pkg::NM-1:0]      m_ar_ready,
    output axil_xbar_pkg::axil_r_t            m_r [axil_xbar_pkg::NM],
    output logic [axil_xbar_pkg::NM-1:0]      m_r_valid,
    input  logic [axil_xbar_pkg::NM-1:0]      m_r_ready,
    output axil_xbar_pkg::axil_ar_t           s_ar [axil_xbar_pkg::NS],
    output logic [axil_xbar_pkg::NS-1:0]      s_ar_valid,
    input  logic [axil_xbar_pkg::NS-1:0]      s_ar_ready,
    input  axil_xbar_pkg::axil_r_t            s_r [axil_xbar_pkg::NS],
    input  logic [axil_xbar_pkg::NS-1:0]      s_r_valid,
    output logic [axil_xbar_pkg::NS-1:0]      s_r_ready
);

    logic [axil_xbar_pkg::TGT_W-1:0] tgt [axil_xbar_pkg::NM];
    logic [axil_xbar_pkg::NM-1:0]    req [axil_xbar_pkg::NS+1];
    logic [axil_xbar_pkg::NM-1:0]    grant [axil_xbar_pkg::NS+1];
    logic [axil_xbar_pkg::NS:0]      busy;
    logic [axil_xbar_pkg::NS:0]      rel;

    axil_xbar_pkg::axil_ar_t    t_ar [axil_xbar_pkg::NS+1];
    axil_xbar_pkg::axil_r_t     t_r [axil_xbar_pkg::NS+1];
    logic [axil_xbar_pkg::NS:0] t_ar_valid, t_ar_ready;
    logic [axil_xbar_pkg::NS:0] t_r_valid, t_r_ready;

    logic de_ready;
    logic de_rvalid;

    for (genvar m = 0; m < axil_xbar_pkg::NM; m++) begin : g_dec
        axil_addr_decode dec (
            .addr(m_ar[m].addr),
            .tgt (tgt[m])
        );
    end

    for (genvar t = 0; t <= axil_xbar_pkg::NS; t++) begin : g_arb
        axil_rr_arbiter arb (
            .clock        (clock),
            .arst_n       (arst_n),
            .req          (req[t]),
            .grant_release(rel[t]),
            .grant        (grant[t]),
            .busy         (busy[t])
        );
        assign rel[t] = t_r_valid[t] && t_r_ready[t];
    end

    always_comb begin
        for (int t = 0; t <= axil_xbar_pkg::NS; t++) begin
            for (int m = 0; m < axil_xbar_pkg::NM; m++) begin
                req[t][m] = m_ar_valid[m] && !busy[t] && (int'(tgt[m]) == t);
            end
        end
    end

    always_comb begin
        for (int t = 0; t <= axil_xbar_pkg::NS; t++) begin
            t_ar[t]       = '0;
            t_ar_valid[t] = 1'b0;
            t_r_ready[t]  = 1'b0;
            for (int m = 0; m < axil_xbar_pkg::NM; m++) begin
                if (grant[t][m]) begin
                    t_ar[t]       = m_ar[m];
                    t_ar_valid[t] = m_ar_valid[m];
                    t_r_ready[t]  = m_r_ready[m];
                end
            end
        end
    end

    always_comb begin
        for (int m = 0; m < axil_xbar_pkg::NM; m++) begin
            m_ar_ready[m] = 1'b0;
            m_r[m]        = '0;
            m_r_valid[m]  = 1'b0;
            for (int t = 0; t <= axil_xbar_pkg::NS; t++) begin
                if (grant[t][m]) begin
                    m_ar_ready[m] = t_ar_ready[t];
                    m_r[m]        = t_r[t];
                    m_r_valid[m]  = t_r_valid[t];
                end
            end
        end
    end

    for (genvar s = 0; s < axil_xbar_pkg::NS; s++) begin : g_port
        assign s_ar[s]       = t_ar[s];
        assign s_ar_valid[s] = t_ar_valid[s];
        assign s_r_ready[s]  = t_r_ready[s];
        assign t_ar_ready[s] = s_ar_ready[s];
        assign t_r[s]        = s_r[s];
        assign t_r_valid[s]  = s_r_valid[s];
    end

    // Unmapped reads return zero data with DECERR
    assign t_ar_ready[axil_xbar_pkg::NS] = de_ready;
    assign t_r[axil_xbar_pkg::NS]  = '{data: '0, resp: axil_xbar_pkg::RESP_DECERR};
    assign t_r_valid[axil_xbar_pkg::NS]  = de_rvalid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            de_ready  <= 1'b0;
            de_rvalid <= 1'b0;
        end else begin
            de_ready <= busy[axil_xbar_pkg::NS] && !de_ready && !de_rvalid;
            if (de_ready && t_ar_valid[axil_xbar_pkg::NS]) begin
                de_rvalid <= 1'b1;
            end else if (de_rvalid && t_r_ready[axil_xbar_pkg::NS]) begin
                de_rvalid <= 1'b0;
            end
        end
    end

endmodule

/* logic/axil_reg_bank.sv */
module axil_reg_bank (
    input  logic                    clock,
    input  logic                    arst_n,
    input  axil_xbar_pkg::axil_aw_t aw,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  axil_xbar_pkg::axil_w_t  w,
    input  logic                    w_valid,
    output logic                    w_ready,
    output axil_xbar_pkg::axil_b_t  b,
    output logic                    b_valid,
    input  logic                    b_ready,
    input  axil_xbar_pkg::axil_ar_t ar,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    output axil_xbar_pkg::axil_r_t  r,
    output logic                    r_valid,
    input  logic                    r_ready
);

    logic [axil_xbar_pkg::DATA_W-1:0] regs [4];
    logic [axil_xbar_pkg::DATA_W-1:0] r_data;
    logic                             wr_fire;
    logic                             rd_fire;

    // Address and data taken together, one response at a time
    assign wr_fire  = aw_valid && w_valid && !b_valid;
    assign aw_ready = wr_fire;
    assign w_ready  = wr_fire;
    assign b        = '{resp: axil_xbar_pkg::RESP_OKAY};

    assign ar_ready = !r_valid;
    assign rd_fire  = ar_valid && ar_ready;
    assign r        = '{data: r_data, resp: axil_xbar_pkg::RESP_OKAY};

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                // Byte lanes with strobe clear keep their value
                for (int i = 0; i < axil_xbar_pkg::STRB_W; i++) begin
                    if (w.strb[i]) begin
                        regs[aw.addr[3:2]][8*i +: 8] <= w.data[8*i +: 8];
                    end
                end
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_fire) begin
            r_data <= regs[ar.addr[3:2]];
        end
    end

endmodule

/* logic/axil_xbar_top.sv */
module axil_xbar_top (
    input  logic                         clock,
    input  logic                         arst_n,
    input  axil_xbar_pkg::axil_aw_t      m_aw [axil_xbar_pkg::NM],
    input  logic [axil_xbar_pkg::NM-1:0] m_aw_valid,
    output logic [axil_xbar_pkg::NM-1:0] m_aw_ready,
    input  axil_xbar_pkg::axil_w_t       m_w [axil_xbar_pkg::NM],
    input  logic [axil_xbar_pkg::NM-1:0] m_w_valid,
    output logic [axil_xbar_pkg::NM-1:0] m_w_ready,
    output axil_xbar_pkg::axil_b_t       m_b [axil_xbar_pkg::NM],
    output logic [axil_xbar_pkg::NM-1:0] m_b_valid,
    input  logic [axil_xbar_pkg::NM-1:0] m_b_ready,
    input  axil_xbar_pkg::axil_ar_t      m_ar [axil_xbar_pkg::NM],
    input  logic [axil_xbar_pkg::NM-1:0] m_ar_valid,
    output logic [axil_xbar_pkg::NM-1:0] m_ar_ready,
    output axil_xbar_pkg::axil_r_t       m_r [axil_xbar_pkg::NM],
    output logic [axil_xbar_pkg::NM-1:0] m_r_valid,
    input  logic [axil_xbar_pkg::NM-1:0] m_r_ready
);

    // Peripheral-side bundles, one element per register bank
    axil_xbar_pkg::axil_aw_t      s_aw [axil_xbar_pkg::NS];
    axil_xbar_pkg::axil_w_t       s_w [axil_xbar_pkg::NS];
    axil_xbar_pkg::axil_b_t       s_b [axil_xbar_pkg::NS];
    axil_xbar_pkg::axil_ar_t      s_ar [axil_xbar_pkg::NS];
    axil_xbar_pkg::axil_r_t       s_r [axil_xbar_pkg::NS];
    logic [axil_xbar_pkg::NS-1:0] s_aw_valid, s_aw_ready;
    logic [axil_xbar_pkg::NS-1:0] s_w_valid, s_w_ready;
    logic [axil_xbar_pkg::NS-1:0] s_b_valid, s_b_ready;
    logic [axil_xbar_pkg::NS-1:0] s_ar_valid, s_ar_ready;
    logic [axil_xbar_pkg::NS-1:0] s_r_valid, s_r_ready;

    axil_xbar_write xbar_write (
        .clock     (clock),
        .arst_n    (arst_n),
        .m_aw      (m_aw),
        .m_aw_valid(m_aw_valid),
        .m_aw_ready(m_aw_ready),
        .m_w       (m_w),
        .m_w_valid (m_w_valid),
        .m_w_ready (m_w_ready),
        .m_b       (m_b),
        .m_b_valid (m_b_valid),
        .m_b_ready (m_b_ready),
        .s_aw      (s_aw),
        .s_aw_valid(s_aw_valid),
        .s_aw_ready(s_aw_ready),
        .s_w       (s_w),
        .s_w_valid (s_w_valid),
        .s_w_ready (s_w_ready),
        .s_b       (s_b),
        .s_b_valid (s_b_valid),
        .s_b_ready (s_b_ready)
    );

    axil_xbar_read xbar_read (
        .clock     (clock),
        .arst_n    (arst_n),
        .m_ar      (m_ar),
        .m_ar_valid(m_ar_valid),
        .m_ar_ready(m_ar_ready),
        .m_r       (m_r),
        .m_r_valid (m_r_valid),
        .m_r_ready (m_r_ready),
        .s_ar      (s_ar),
        .s_ar_valid(s_ar_valid),
        .s_ar_ready(s_ar_ready),
        .s_r       (s_r),
        .s_r_valid (s_r_valid),
        .s_r_ready (s_r_ready)
    );

    for (genvar s = 0; s < axil_xbar_pkg::NS; s++) begin : g_bank
        axil_reg_bank bank (
            .clock   (clock),
            .arst_n  (arst_n),
            .aw      (s_aw[s]),
            .aw_valid(s_aw_valid[s]),
            .aw_ready(s_aw_ready[s]),
            .w       (s_w[s]),
            .w_valid (s_w_valid[s]),
            .w_ready (s_w_ready[s]),
            .b       (s_b[s]),
            .b_valid (s_b_valid[s]),
            .b_ready (s_b_ready[s]),
            .ar      (s_ar[s]),
            .ar_valid(s_ar_valid[s]),
            .ar_ready(s_ar_ready[s]),
            .r       (s_r[s]),
            .r_valid (s_r_valid[s]),
            .r_ready (s_r_ready[s])
        );
    end

endmodule

/* tests/axil_xbar_assert.sv */
module axil_xbar_assert (
    input logic                         clock,
    input logic                         arst_n,
    input axil_xbar_pkg::axil_aw_t      m_aw [axil_xbar_pkg::NM],
    input logic [axil_xbar_pkg::NM-1:0] m_aw_valid,
    input logic [axil_xbar_pkg::NM-1:0] m_aw_ready,
    input axil_xbar_pkg::axil_w_t       m_w [axil_xbar_pkg::NM],
    input logic [axil_xbar_pkg::NM-1:0] m_w_valid,
    input logic [axil_xbar_pkg::NM-1:0] m_w_ready,
    input axil_xbar_pkg::axil_b_t       m_b [axil_xbar_pkg::NM],
    input logic [axil_xbar_pkg::NM-1:0] m_b_valid,
    input logic [axil_xbar_pkg::NM-1:0] m_b_ready,
    input axil_xbar_pkg::axil_ar_t      m_ar [axil_xbar_pkg::NM],
    input logic [axil_xbar_pkg::NM-1:0] m_ar_valid,
    input logic [axil_xbar_pkg::NM-1:0] m_ar_ready,
    input axil_xbar_pkg::axil_r_t       m_r [axil_xbar_pkg::NM],
    input logic [axil_xbar_pkg::NM-1:0] m_r_valid,
    input logic [axil_xbar_pkg::NM-1:0] m_r_ready
);

    for (genvar m = 0; m < axil_xbar_pkg::NM; m++) begin : g_master
        // Requests held until accepted
        aw_hold: assert property (@(posedge clock) disable iff (!arst_n)
            m_aw_valid[m] && !m_aw_ready[m] |=> m_aw_valid[m] && $stable(m_aw[m]))
            else $error("write address changed before it was accepted");
        w_hold: assert property (@(posedge clock) disable iff (!arst_n)
            m_w_valid[m] && !m_w_ready[m] |=> m_w_valid[m] && $stable(m_w[m]))
            else $error("write data changed before it was accepted");
        ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
            m_ar_valid[m] && !m_ar_ready[m] |=> m_ar_valid[m] && $stable(m_ar[m]))
            else $error("read address changed before it was accepted");

        // Responses held under back-pressure
        b_hold: assert property (@(posedge clock) disable iff (!arst_n)
            m_b_valid[m] && !m_b_ready[m] |=> m_b_valid[m] && $stable(m_b[m]))
            else $error("write response changed while b_ready was low");
        r_hold: assert property (@(posedge clock) disable iff (!arst_n)
            m_r_valid[m] && !m_r_ready[m] |=> m_r_valid[m] && $stable(m_r[m]))
            else $error("read data changed while r_ready was low");
    end

    quiet_in_reset: assert property (@(posedge clock)
        !arst_n |-> m_b_valid == '0 && m_r_valid == '0)
        else $error("response valid during reset");

endmodule

bind axil_xbar_top axil_xbar_assert assert0 (.*);

/* tests/axil_xbar_tb.sv */
module axil_xbar_tb;

    logic clock = 1'b0;
    logic arst_n;

    axil_xbar_pkg::axil_aw_t      m_aw [axil_xbar_pkg::NM];
    logic [axil_xbar_pkg::NM-1:0] m_aw_valid;
    logic [axil_xbar_pkg::NM-1:0] m_aw_ready;
    axil_xbar_pkg::axil_w_t       m_w [axil_xbar_pkg::NM];
    logic [axil_xbar_pkg::NM-1:0] m_w_valid;
    logic [axil_xbar_pkg::NM-1:0] m_w_ready;
    axil_xbar_pkg::axil_b_t       m_b [axil_xbar_pkg::NM];
    logic [axil_xbar_pkg::NM-1:0] m_b_valid;
    logic [axil_xbar_pkg::NM-1:0] m_b_ready;
    axil_xbar_pkg::axil_ar_t      m_ar [axil_xbar_pkg::NM];
    logic [axil_xbar_pkg::NM-1:0] m_ar_valid;
    logic [axil_xbar_pkg::NM-1:0] m_ar_ready;
    axil_xbar_pkg::axil_r_t       m_r [axil_xbar_pkg::NM];
    logic [axil_xbar_pkg::NM-1:0] m_r_valid;
    logic [axil_xbar_pkg::NM-1:0] m_r_ready;

    logic [31:0] lfsr_state = 32'hca5c_040f;
    string       test_name;
    int          tests_run = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          errors_before = 0;
    // Cycles any single wait may take
    int          wait_limit = 40;

    axil_xbar_top dut0 (.*);

    always #20 clock = ~clock;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] v;
        for (int i = 0; i < 32; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    // Distinct word per register, every address bit matters
    function automatic logic [31:0] pattern_for(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    function automatic axil_xbar_pkg::axil_b_t make_b(input logic [1:0] resp);
        axil_xbar_pkg::axil_b_t v;
        v.resp = resp;
        return v;
    endfunction

    function automatic axil_xbar_pkg::axil_r_t make_r(input logic [31:0] data,
                                                      input logic [1:0] resp);
        axil_xbar_pkg::axil_r_t v;
        v.data = data;
        v.resp = resp;
        return v;
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("%s: timed out waiting for %s", test_name, what);
        $display("Something failed");
        $finish;
    endtask

    task automatic check_b(input axil_xbar_pkg::axil_b_t exp, input axil_xbar_pkg::axil_b_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s: expected resp %0d, got resp %0d", test_name, exp.resp,
                     act.resp);
        end
    endtask

    task automatic check_r(input axil_xbar_pkg::axil_r_t exp, input axil_xbar_pkg::axil_r_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s: expected data %h resp %0d, got data %h resp %0d", test_name,
                     exp.data, exp.resp, act.data, act.resp);
        end
    endtask

    task automatic write_req(input int m, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output axil_xbar_pkg::axil_b_t resp);
        bit aw_done;
        bit w_done;
        bit got;
        int cnt;
        aw_done = 1'b0;
        w_done  = 1'b0;
        got     = 1'b0;
        cnt     = 0;
        @(posedge clock);
        m_aw[m].addr  <= addr;
        m_w[m].data   <= data;
        m_w[m].strb   <= strb;
        m_aw_valid[m] <= 1'b1;
        m_w_valid[m]  <= 1'b1;
        // Ready sampled mid-cycle, transfer on the following edge
        while (!(aw_done && w_done)) begin
            @(negedge clock);
            if (!aw_done && m_aw_ready[m]) begin
                aw_done = 1'b1;
            end
            if (!w_done && m_w_ready[m]) begin
                w_done = 1'b1;
            end
            @(posedge clock);
            if (aw_done) begin
                m_aw_valid[m] <= 1'b0;
            end
            if (w_done) begin
                m_w_valid[m] <= 1'b0;
            end
            cnt++;
            if (!(aw_done && w_done) && cnt > wait_limit) begin
                abort_on_timeout("write address and data to be accepted");
            end
        end
        cnt = 0;
        while (!got) begin
            @(negedge clock);
            if (m_b_valid[m] && m_b_ready[m]) begin
                resp = m_b[m];
                got  = 1'b1;
            end
            cnt++;
            if (!got && cnt > wait_limit) begin
                abort_on_timeout("write response");
            end
        end
        @(posedge clock);
    endtask

    task automatic read_req(input int m, input logic [31:0] addr,
                            output axil_xbar_pkg::axil_r_t resp);
        bit done;
        int cnt;
        done = 1'b0;
        cnt  = 0;
        @(posedge clock);
        m_ar[m].addr  <= addr;
        m_ar_valid[m] <= 1'b1;
        while (!done) begin
            @(negedge clock);
            done = m_ar_ready[m];
            @(posedge clock);
            if (done) begin
                m_ar_valid[m] <= 1'b0;
            end
            cnt++;
            if (!done && cnt > wait_limit) begin
                abort_on_timeout("read address to be accepted");
            end
        end
        done = 1'b0;
        cnt  = 0;
        while (!done) begin
            @(negedge clock);
            if (m_r_valid[m] && m_r_ready[m]) begin
                resp = m_r[m];
                done = 1'b1;
            end
            cnt++;
            if (!done && cnt > wait_limit) begin
                abort_on_timeout("read data");
            end
        end
        @(posedge clock);
    endtask

    // Both masters' responses must still be up when ready returns
    task automatic stall_responses(input bit reads, input int cycles);
        bit held;
        @(posedge clock);
        if (reads) begin
            m_r_ready <= '0;
        end else begin
            m_b_ready <= '0;
        end
        repeat (cycles) @(posedge clock);
        @(negedge clock);
        held = reads ? &m_r_valid : &m_b_valid;
        check_count++;
        if (!held) begin
            error_count++;
            $display("%s: a response was dropped while ready was low", test_name);
        end
        @(posedge clock);
        m_r_ready <= '1;
        m_b_ready <= '1;
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = error_count;
        tests_run++;
    endtask

    task automatic finish_test();
        if (error_count == errors_before) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: %0d error(s)", test_name, error_count - errors_before);
        end
    endtask

    task automatic test_reg_rw();
        logic [31:0]            addr;
        axil_xbar_pkg::axil_b_t b;
        axil_xbar_pkg::axil_r_t r;
        start_test("reg_rw");
        // Fill everything first so aliasing between registers shows up
        for (int bank = 0; bank < 3; bank++) begin
            for (int idx = 0; idx < 4; idx++) begin
                addr = 32'h1000 * (bank + 1) + 4 * idx;
                write_req(0, addr, pattern_for(addr), 4'hf, b);
                check_b(make_b(axil_xbar_pkg::RESP_OKAY), b);
            end
        end
        for (int bank = 0; bank < 3; bank++) begin
            for (int idx = 0; idx < 4; idx++) begin
                addr = 32'h1000 * (bank + 1) + 4 * idx;
                read_req(0, addr, r);
                check_r(make_r(pattern_for(addr), axil_xbar_pkg::RESP_OKAY), r);
            end
        end
        finish_test();
    endtask

    task automatic test_strobes();
        axil_xbar_pkg::axil_b_t b;
        axil_xbar_pkg::axil_r_t r;
        start_test("strobes");
        write_req(0, 32'h0000_2008, 32'hffff_ffff, 4'b1111, b);
        check_b(make_b(axil_xbar_pkg::RESP_OKAY), b);
        // Clears bytes 0 and 2 only
        write_req(0, 32'h0000_2008, 32'h0000_0000, 4'b0101, b);
        check_b(make_b(axil_xbar_pkg::RESP_OKAY), b);
        read_req(0, 32'h0000_2008, r);
        check_r(make_r(32'hff00_ff00, axil_xbar_pkg::RESP_OKAY), r);
        finish_test();
    endtask

    task automatic test_decode_error();
        axil_xbar_pkg::axil_b_t b;
        axil_xbar_pkg::axil_r_t r;
        start_test("decode_error");
        write_req(0, 32'h0000_8000, 32'h1234_5678, 4'hf, b);
        check_b(make_b(axil_xbar_pkg::RESP_DECERR), b);
        read_req(0, 32'h0000_8000, r);
        check_r(make_r(32'h0000_0000, axil_xbar_pkg::RESP_DECERR), r);
        finish_test();
    endtask

    task automatic test_same_target();
        axil_xbar_pkg::axil_b_t b0;
        axil_xbar_pkg::axil_b_t b1;
        axil_xbar_pkg::axil_r_t r;
        start_test("same_target");
        fork
            write_req(0, 32'h0000_3008, 32'h0000_aaaa, 4'hf, b0);
            write_req(1, 32'h0000_3008, 32'h5555_0000, 4'hf, b1);
        join
        check_b(make_b(axil_xbar_pkg::RESP_OKAY), b0);
        check_b(make_b(axil_xbar_pkg::RESP_OKAY), b1);
        // Master 0 goes first after reset, so master 1 writes last
        read_req(0, 32'h0000_3008, r);
        check_r(make_r(32'h5555_0000, axil_xbar_pkg::RESP_OKAY), r);
        finish_test();
    endtask

    task automatic test_backpressure();
        logic [31:0]            d0;
        logic [31:0]            d1;
        axil_xbar_pkg::axil_b_t b0;
        axil_xbar_pkg::axil_b_t b1;
        axil_xbar_pkg::axil_r_t r0;
        axil_xbar_pkg::axil_r_t r1;
        start_test("backpressure");
        d0 = random_word();
        d1 = random_word();
        fork
            write_req(0, 32'h0000_1004, d0, 4'hf, b0);
            write_req(1, 32'h0000_300c, d1, 4'hf, b1);
            stall_responses(1'b0, 6);
        join
        check_b(make_b(axil_xbar_pkg::RESP_OKAY), b0);
        check_b(make_b(axil_xbar_pkg::RESP_OKAY), b1);
        fork
            read_req(0, 32'h0000_1004, r0);
            read_req(1, 32'h0000_300c, r1);
            stall_responses(1'b1, 6);
        join
        check_r(make_r(d0, axil_xbar_pkg::RESP_OKAY), r0);
        check_r(make_r(d1, axil_xbar_pkg::RESP_OKAY), r1);
        finish_test();
    endtask

    initial begin
        for (int i = 0; i < axil_xbar_pkg::NM; i++) begin
            m_aw[i] = '0;
            m_w[i]  = '0;
            m_ar[i] = '0;
        end
        m_aw_valid = '0;
        m_w_valid  = '0;
        m_ar_valid = '0;
        m_b_ready  = '1;
        m_r_ready  = '1;
        arst_n     = 1'b0;
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;

        // Arbitration order is only known straight after reset
        test_same_target();
        test_reg_rw();
        test_strobes();
        test_decode_error();
        test_backpressure();

        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* axil_xbar_top.f */
logic/axil_xbar_pkg.sv
logic/axil_addr_decode.sv
logic/axil_rr_arbiter.sv
logic/axil_xbar_write.sv
logic/axil_xbar_read.sv
logic/axil_reg_bank.sv
logic/axil_xbar_top.sv
tests/axil_xbar_assert.sv
tests/axil_xbar_tb.sv

/* Makefile */
TOP = axil_xbar_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f axil_xbar_top.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Everything OK" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
